//--- mac_patterns.txt
# Columns: test name, op (0 multiply, 1 multiply-accumulate), a, b, acc,
# expected product, expected flags {negative, zero}; all numbers in hex.
mul_basic     0 00000003 00000005 00000000 0000000f 0
mul_zero      0 12345678 00000000 00000000 00000000 1
mul_neg       0 00010000 00008000 00000000 80000000 2
mla_basic     1 00000007 00000006 00000064 0000008e 0
mla_wrap      1 00000002 7fffffff 00000003 00000001 0
mla_wrap_zero 1 ffffffff 00000001 00000001 00000000 1
mul_max       0 ffffffff ffffffff 00000000 00000001 0
mul_hi        0 0000ffff 0000ffff 00000000 fffe0001 2
mul_wrap      0 00010000 00010000 00000000 00000000 1
mla_neg       1 00001000 00001000 80000000 81000000 2
mul_big       0 12345678 00000010 00000000 23456780 0
mul_one       0 deadbeef 00000001 00000000 deadbeef 2
mla_acc_only  1 00000000 abcdef01 13579bdf 13579bdf 0
mul_pow       0 00000100 00abcdef 00000000 abcdef00 2
bp_0          0 00000011 00000011 00000000 00000121 0
bp_1          1 00000020 00000030 00000001 00000601 0
bp_2          0 0000abcd 00000002 00000000 0001579a 0
bp_3          0 40000000 00000002 00000000 80000000 2
bp_4          1 00000003 00000003 fffffff7 00000000 1
bp_5          0 00000005 00000005 00000000 00000019 0
bp_6          0 00000100 00000100 00000000 00010000 0
bp_7          1 00000001 00000001 00000001 00000002 0

//--- compile.f
+incdir+.
mac_pkg.sv
mac_cmd_capture.sv
op_fifo.sv
booth_multiplier.sv
mac_dispatch.sv
mac_top.sv
tb_mac_top.sv

//--- Bender.yml
package:
  name: mac_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mac_pkg.sv
      - mac_cmd_capture.sv
      - op_fifo.sv
      - booth_multiplier.sv
      - mac_dispatch.sv
      - mac_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mac_top.sv

//--- tb_mac_top.sv
`default_nettype none

`include "mac_defines.svh"

module tb_mac_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mac_pkg::*;

    localparam int MAX_PATTERNS    = 32;
    localparam int SINGLE_COUNT    = 3;
    localparam int BURST_COUNT     = 8;
    localparam int BP_HOLD         = 400;
    localparam int MAX_OUTSTANDING = 3;
    localparam int DRAIN_CYCLES    = 2 * (`MAC_WIDTH + 3);

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_stall;
    logic                      i_req;
    mac_op_t                   i_op;
    logic [`MAC_WIDTH-1:0]     i_a;
    logic [`MAC_WIDTH-1:0]     i_b;
    logic [`MAC_WIDTH-1:0]     i_acc;
    logic                      o_drop;
    logic                      i_res_pop;
    logic                      o_res_valid;
    logic [`MAC_TAG_WIDTH-1:0] o_res_tag;
    logic [`MAC_WIDTH-1:0]     o_res_product;
    logic [1:0]                o_res_flags;

    logic [8*24-1:0]           pat_name    [MAX_PATTERNS];
    logic                      pat_op      [MAX_PATTERNS];
    logic [`MAC_WIDTH-1:0]     pat_a       [MAX_PATTERNS];
    logic [`MAC_WIDTH-1:0]     pat_b       [MAX_PATTERNS];
    logic [`MAC_WIDTH-1:0]     pat_acc     [MAX_PATTERNS];
    logic [`MAC_WIDTH-1:0]     pat_product [MAX_PATTERNS];
    logic [1:0]                pat_flags   [MAX_PATTERNS];
    int                        pat_count;

    // Pattern index of every accepted request, looked up by its tag.
    int                        exp_by_tag  [1 << `MAC_TAG_WIDTH];
    logic [`MAC_TAG_WIDTH-1:0] next_tag;
    int                        accepted_count;
    int                        rx_count;
    int                        pop_count;
    int                        pass_count;
    int                        fail_count;
    int                        drop_count;
    int                        cycle_count;
    int                        max_cycles;
    int                        pop_wait;
    logic                      stall_en;
    logic                      pop_en;
    logic                      pop_random;
    logic [31:0]               gap_state;
    logic [31:0]               stall_state;
    logic [31:0]               pop_state;

    mac_top mac_top_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_req         (i_req),
        .i_op          (i_op),
        .i_a           (i_a),
        .i_b           (i_b),
        .i_acc         (i_acc),
        .o_drop        (o_drop),
        .i_res_pop     (i_res_pop),
        .o_res_valid   (o_res_valid),
        .o_res_tag     (o_res_tag),
        .o_res_product (o_res_product),
        .o_res_flags   (o_res_flags)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic read_patterns();
        int              fd;
        int              r;
        logic [8*24-1:0] tok;
        logic [8*128-1:0] rest;
        logic [31:0]     op;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     acc;
        logic [31:0]     product;
        logic [31:0]     flags;
        pat_count = 0;
        fd = $fopen("mac_patterns.txt", "r");
        if (fd == 0)
            $display("Cannot open mac_patterns.txt for reading");
        else
        begin
            r = $fscanf(fd, "%s", tok);
            while (r == 1)
            begin
                if (tok == "#")
                    r = $fgets(rest, fd);
                else
                begin
                    r = $fscanf(fd, "%h %h %h %h %h %h", op, a, b, acc, product, flags);
                    if (r == 6 && pat_count < MAX_PATTERNS)
                    begin
                        pat_name[pat_count]    = tok;
                        pat_op[pat_count]      = op[0];
                        pat_a[pat_count]       = a;
                        pat_b[pat_count]       = b;
                        pat_acc[pat_count]     = acc;
                        pat_product[pat_count] = product;
                        pat_flags[pat_count]   = flags[1:0];
                        pat_count              = pat_count + 1;
                    end
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic send_request(input int idx, output logic dropped);
        i_req = 1'b1;
        i_op  = pat_op[idx] ? OP_MLA : OP_MUL;
        i_a   = pat_a[idx];
        i_b   = pat_b[idx];
        i_acc = pat_acc[idx];
        next_cycle();
        i_req   = 1'b0;
        dropped = o_drop;
        if (!dropped)
        begin
            exp_by_tag[next_tag] = idx;
            next_tag             = next_tag + 1'b1;
            accepted_count       = accepted_count + 1;
        end
    endtask

    task automatic check_result();
        logic [`MAC_TAG_WIDTH-1:0] exp_tag;
        int                        idx;
        logic                      ok;
        if (rx_count >= accepted_count)
        begin
            $display("A result with tag %0d arrived with no request outstanding", o_res_tag);
            fail_count = fail_count + 1;
        end
        else
        begin
            exp_tag = rx_count[`MAC_TAG_WIDTH-1:0];
            idx     = exp_by_tag[exp_tag];
            ok      = 1'b1;
            if (o_res_tag !== exp_tag)
            begin
                $display("Error: %0s tag expected %0d, actual %0d", pat_name[idx], exp_tag,
                         o_res_tag);
                ok = 1'b0;
            end
            if (o_res_product !== pat_product[idx])
            begin
                $display("Error: %0s product expected %h, actual %h", pat_name[idx],
                         pat_product[idx], o_res_product);
                ok = 1'b0;
            end
            if (o_res_flags !== pat_flags[idx])
            begin
                $display("Error: %0s flags expected %b, actual %b", pat_name[idx],
                         pat_flags[idx], o_res_flags);
                ok = 1'b0;
            end
            if (ok)
            begin
                $display("%0s: ok, tag %0d product %h", pat_name[idx], o_res_tag, o_res_product);
                pass_count = pass_count + 1;
            end
            else
                fail_count = fail_count + 1;
            rx_count = rx_count + 1;
        end
    endtask

    task automatic wait_results();
        while (rx_count < accepted_count)
            next_cycle();
    endtask

    // ########################################################################
    // Background processes
    // ########################################################################

    always @(posedge i_clk)
    begin
        #2;
        if (stall_en)
        begin
            stall_state = lcg_next(stall_state);
            i_stall     = (stall_state[31:29] == 3'd0);
        end
        else
            i_stall = 1'b0;
    end

    // Results are sampled 1 ns after the edge and the pop is driven at 2 ns.
    always @(posedge i_clk)
    begin : pop_results
        logic pop_now;
        #1;
        pop_now = 1'b0;
        if (pop_en && o_res_valid)
        begin
            if (pop_wait > 0)
                pop_wait = pop_wait - 1;
            else
            begin
                check_result();
                pop_now   = 1'b1;
                pop_count = pop_count + 1;
                if (pop_random)
                begin
                    pop_state = lcg_next(pop_state);
                    pop_wait  = int'(pop_state[31:30]);
                end
            end
        end
        #1;
        i_res_pop = pop_now;
    end

    always @(posedge i_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("Timeout: the run reached its limit of %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ########################################################################
    // Test sequence
    // ########################################################################

    task automatic run_checks();
        logic       dropped;
        logic [1:0] bad_state;
        int         pop_before;
        int         burst_first;

        // Both outputs must stay low through reset and the idle cycles after it.
        bad_state = 2'b00;
        repeat (13)
        begin
            next_cycle();
            if (cycle_count == 10)
                i_rst = 1'b0;
            if ((o_res_valid !== 1'b0 || o_drop !== 1'b0) && bad_state == 2'b00)
                bad_state = {o_res_valid, o_drop};
        end
        if (bad_state == 2'b00)
        begin
            $display("reset_state: ok");
            pass_count = pass_count + 1;
        end
        else
        begin
            $display("Error: reset_state valid and drop expected 00, actual %b", bad_state);
            fail_count = fail_count + 1;
        end

        // Single requests, popped as soon as they appear.
        pop_en = 1'b1;
        for (int i = 0; i < SINGLE_COUNT; i++)
        begin
            send_request(i, dropped);
            if (dropped)
            begin
                $display("%0s: request dropped although the queue was empty", pat_name[i]);
                fail_count = fail_count + 1;
            end
            wait_results();
        end

        stall_en   = 1'b1;
        pop_random = 1'b1;
        for (int i = SINGLE_COUNT; i < pat_count - BURST_COUNT; i++)
        begin
            gap_state = lcg_next(gap_state);
            repeat (gap_state[31:29])
                next_cycle();
            while (accepted_count - rx_count >= MAX_OUTSTANDING)
                next_cycle();
            send_request(i, dropped);
            if (dropped)
            begin
                $display("%0s: request dropped although the queue had room", pat_name[i]);
                fail_count = fail_count + 1;
            end
        end
        wait_results();

        // Burst with the result side blocked, so the queues fill up.
        pop_en      = 1'b0;
        pop_before  = pop_count;
        burst_first = pat_count - BURST_COUNT;
        for (int i = burst_first; i < pat_count; i++)
        begin
            send_request(i, dropped);
            if (dropped)
            begin
                drop_count = drop_count + 1;
                if (i - burst_first < `MAC_CMD_DEPTH)
                begin
                    $display("%0s: dropped while the command queue had room", pat_name[i]);
                    fail_count = fail_count + 1;
                end
                else
                    $display("%0s: dropped, command queue full", pat_name[i]);
            end
        end
        repeat (BP_HOLD)
            next_cycle();
        pop_en = 1'b1;
        wait_results();
        // A request that was flagged as dropped but still executed would arrive in this window.
        repeat (DRAIN_CYCLES)
            next_cycle();
        if (pop_count - pop_before + drop_count != BURST_COUNT)
        begin
            $display("Error: back_pressure results plus drops expected %0d, actual %0d",
                     BURST_COUNT, pop_count - pop_before + drop_count);
            fail_count = fail_count + 1;
        end
        else
        begin
            $display("back_pressure: ok, %0d results and %0d drops", pop_count - pop_before,
                     drop_count);
            pass_count = pass_count + 1;
        end
    endtask

    initial
    begin : run_tests
        i_clk          = 1'b0;
        i_rst          = 1'b1;
        i_stall        = 1'b0;
        i_req          = 1'b0;
        i_op           = OP_MUL;
        i_a            = '0;
        i_b            = '0;
        i_acc          = '0;
        i_res_pop      = 1'b0;
        next_tag       = '0;
        accepted_count = 0;
        rx_count       = 0;
        pop_count      = 0;
        pass_count     = 0;
        fail_count     = 0;
        drop_count     = 0;
        cycle_count    = 0;
        pop_wait       = 0;
        stall_en       = 1'b0;
        pop_en         = 1'b0;
        pop_random     = 1'b0;
        gap_state      = 32'hd748;
        stall_state    = lcg_next(gap_state);
        pop_state      = lcg_next(stall_state);

        read_patterns();
        max_cycles = pat_count * 40 + BP_HOLD + DRAIN_CYCLES + 200;
        if (pat_count < SINGLE_COUNT + BURST_COUNT)
        begin
            $display("The pattern file holds only %0d usable lines", pat_count);
            fail_count = fail_count + 1;
        end
        else
            run_checks();

        $display("Summary: %0d passed, %0d failed, %0d dropped", pass_count, fail_count,
                 drop_count);
        if (fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mac_top.sv
`default_nettype none

`include "mac_defines.svh"

module mac_top
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_stall,

    input  logic                       i_req,
    input  mac_pkg::mac_op_t           i_op,
    input  logic [`MAC_WIDTH-1:0]      i_a,
    input  logic [`MAC_WIDTH-1:0]      i_b,
    input  logic [`MAC_WIDTH-1:0]      i_acc,
    output logic                       o_drop,

    input  logic                       i_res_pop,
    output logic                       o_res_valid,
    output logic [`MAC_TAG_WIDTH-1:0]  o_res_tag,
    output logic [`MAC_WIDTH-1:0]      o_res_product,
    output logic [1:0]                 o_res_flags
);

    import mac_pkg::*;

    logic     cmd_push;
    mac_cmd_t cmd_in;
    logic     cmd_full;
    logic     cmd_empty;
    logic     cmd_pop;
    mac_cmd_t cmd_head;

    logic     res_push;
    mac_res_t res_in;
    logic     res_full;
    logic     res_almost_full;
    logic     res_empty;
    mac_res_t res_head;

    // ########################################################################
    // Request side
    // ########################################################################

    mac_cmd_capture mac_cmd_capture_i
    (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_req  (i_req),
        .i_op   (i_op),
        .i_a    (i_a),
        .i_b    (i_b),
        .i_acc  (i_acc),
        .i_full (cmd_full),
        .o_push (cmd_push),
        .o_cmd  (cmd_in),
        .o_drop (o_drop)
    );

    op_fifo #(.T_DATA(mac_cmd_t), .DEPTH(`MAC_CMD_DEPTH)) cmd_fifo_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_push        (cmd_push),
        .i_data        (cmd_in),
        .i_pop         (cmd_pop),
        .o_data        (cmd_head),
        .o_empty       (cmd_empty),
        .o_full        (cmd_full),
        .o_almost_full ()
    );

    // ########################################################################
    // Execution and result side
    // ########################################################################

    mac_dispatch mac_dispatch_i
    (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_stall          (i_stall),
        .i_cmd_empty      (cmd_empty),
        .i_cmd            (cmd_head),
        .o_cmd_pop        (cmd_pop),
        .i_res_full       (res_full),
        .i_res_count_room (res_almost_full),
        .o_res_push       (res_push),
        .o_res            (res_in)
    );

    op_fifo #(.T_DATA(mac_res_t), .DEPTH(`MAC_RES_DEPTH)) res_fifo_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_push        (res_push),
        .i_data        (res_in),
        .i_pop         (i_res_pop),
        .o_data        (res_head),
        .o_empty       (res_empty),
        .o_full        (res_full),
        .o_almost_full (res_almost_full)
    );

    assign o_res_valid   = !res_empty;
    assign o_res_tag     = res_head.tag;
    assign o_res_product = res_head.product;
    assign o_res_flags   = res_head.flags;

endmodule

`default_nettype wire

//--- mac_dispatch.sv
`default_nettype none

`include "mac_defines.svh"

module mac_dispatch
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_stall,

    input  logic               i_cmd_empty,
    input  mac_pkg::mac_cmd_t  i_cmd,
    output logic               o_cmd_pop,

    input  logic               i_res_full,
    input  logic               i_res_count_room,
    output logic               o_res_push,
    output mac_pkg::mac_res_t  o_res
);

    import mac_pkg::*;

    logic                      mul_busy;
    logic                      mul_done;
    logic [`MAC_WIDTH-1:0]     mul_product;
    logic [1:0]                mul_flags;
    logic                      room;
    logic                      issue;
    logic [`MAC_TAG_WIDTH-1:0] tag_q;
    mac_res_t                  res;

    // In a done cycle the finished result takes one slot, so two must be free.
    assign room  = mul_done ? !i_res_count_room : !i_res_full;
    assign issue = !i_cmd_empty && !mul_busy && room;

    assign o_cmd_pop = issue;

    always_ff @(posedge i_clk)
    begin
        if (issue)
            tag_q <= i_cmd.tag;
    end

    booth_multiplier booth_multiplier_i
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (i_stall),
        .i_start      (issue),
        .i_accumulate (i_cmd.op == OP_MLA),
        .i_a          (i_cmd.a),
        .i_b          (i_cmd.b),
        .i_acc        (i_cmd.acc),
        .o_busy       (mul_busy),
        .o_done       (mul_done),
        .o_product    (mul_product),
        .o_flags      (mul_flags)
    );

    always_comb
    begin
        res.tag     = tag_q;
        res.product = mul_product;
        res.flags   = mul_flags;
    end

    assign o_res_push = mul_done;
    assign o_res      = res;

endmodule

`default_nettype wire

//--- booth_multiplier.sv
`default_nettype none

`include "mac_defines.svh"

module booth_multiplier
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_stall,

    input  logic                   i_start,
    input  logic                   i_accumulate,
    input  logic [`MAC_WIDTH-1:0]  i_a,
    input  logic [`MAC_WIDTH-1:0]  i_b,
    input  logic [`MAC_WIDTH-1:0]  i_acc,

    output logic                   o_busy,
    output logic                   o_done,
    output logic [`MAC_WIDTH-1:0]  o_product,
    output logic [1:0]             o_flags
);

    localparam int W          = `MAC_WIDTH;
    localparam int PW         = 2 * W + 4;
    localparam int LAST_BOOTH = W + 1;
    localparam int CW         = $clog2(W + 3);

    logic [CW-1:0]  count_q;
    logic           done_q;
    logic [PW-1:0]  product_q;
    logic [W-1:0]   a_q;
    logic [W-1:0]   acc_q;
    logic           accumulate_q;

    logic [W+1:0]   multiplicand;
    logic [W+1:0]   multiplicand_neg;
    logic [W+1:0]   addend;
    logic [W+1:0]   sum;
    logic [W-1:0]   sum_acc;
    logic           last_step;

    // ########################################################################
    // Datapath
    // ########################################################################

    assign multiplicand     = {2'b00, a_q};
    assign multiplicand_neg = ~{2'b00, a_q} + 1'b1;

    // Radix-2 Booth recoding on the two low product bits.
    assign addend = (product_q[1:0] == 2'b01) ? multiplicand     :
                    (product_q[1:0] == 2'b10) ? multiplicand_neg :
                                                '0;

    assign sum     = product_q[PW-1:W+2] + addend;
    assign sum_acc = product_q[W:1] + acc_q;

    always_ff @(posedge i_clk)
    begin
        if (count_q == '0)
        begin
            if (i_start)
            begin
                product_q    <= {{(W + 3){1'b0}}, i_b, 1'b0};
                a_q          <= i_a;
                acc_q        <= i_acc;
                accumulate_q <= i_accumulate;
            end
        end
        else if (!i_stall)
        begin
            if (count_q <= CW'(LAST_BOOTH))
                product_q <= {sum[W+1], sum, product_q[W+1:1]};
            else
                product_q <= {product_q[PW-1:W+1], sum_acc, 1'b0};
        end
    end

    // ########################################################################
    // Step control
    // ########################################################################

    assign last_step = ((count_q == CW'(LAST_BOOTH)) && !accumulate_q) ||
                       (count_q == CW'(LAST_BOOTH + 1));

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            count_q <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (count_q == '0)
            begin
                if (i_start)
                    count_q <= CW'(1);
            end
            else if (!i_stall)
            begin
                if (last_step)
                begin
                    count_q <= '0;
                    done_q  <= 1'b1;
                end
                else
                    count_q <= count_q + 1'b1;
            end
        end
    end

    assign o_busy    = (count_q != '0);
    assign o_done    = done_q;
    assign o_product = product_q[W:1];
    // The result stays in the product register until the next start.
    assign o_flags   = {product_q[W], (product_q[W:1] == '0)};

endmodule

`default_nettype wire

//--- op_fifo.sv
`default_nettype none

`include "mac_defines.svh"

module op_fifo
#(
    parameter type T_DATA = logic [`MAC_WIDTH-1:0],
    parameter int  DEPTH  = `MAC_CMD_DEPTH
)
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_push,
    input  T_DATA i_data,
    input  logic  i_pop,
    output T_DATA o_data,

    output logic  o_empty,
    output logic  o_full,
    output logic  o_almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T_DATA             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    // Show-ahead, the head entry is always on the output.
    assign o_data        = mem[rd_ptr];
    assign o_empty       = (count == '0);
    assign o_full        = (count == CNT_W'(DEPTH));
    assign o_almost_full = (count >= CNT_W'(DEPTH - 1));

endmodule

`default_nettype wire

//--- mac_cmd_capture.sv
`default_nettype none

`include "mac_defines.svh"

module mac_cmd_capture
(
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  logic                   i_req,
    input  mac_pkg::mac_op_t       i_op,
    input  logic [`MAC_WIDTH-1:0]  i_a,
    input  logic [`MAC_WIDTH-1:0]  i_b,
    input  logic [`MAC_WIDTH-1:0]  i_acc,

    input  logic                   i_full,
    output logic                   o_push,
    output mac_pkg::mac_cmd_t      o_cmd,
    output logic                   o_drop
);

    import mac_pkg::*;

    logic [`MAC_TAG_WIDTH-1:0] tag_q;
    logic                      drop_q;
    mac_cmd_t                  cmd;

    // A request goes straight into the queue when there is space for it.
    assign o_push = i_req && !i_full;

    always_comb
    begin
        cmd.tag = tag_q;
        cmd.op  = i_op;
        cmd.a   = i_a;
        cmd.b   = i_b;
        cmd.acc = i_acc;
    end

    assign o_cmd = cmd;

    // The tag only moves on an accepted request, so tags stay consecutive.
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            tag_q  <= '0;
            drop_q <= 1'b0;
        end
        else
        begin
            if (o_push)
                tag_q <= tag_q + 1'b1;
            drop_q <= i_req && i_full;
        end
    end

    assign o_drop = drop_q;

endmodule

`default_nettype wire

//--- mac_pkg.sv
`default_nettype none

`include "mac_defines.svh"

package mac_pkg;

    typedef enum logic
    {
        OP_MUL = 1'b0,
        OP_MLA = 1'b1
    } mac_op_t;

    // One queued request, 101 bits wide.
    typedef struct packed
    {
        logic [`MAC_TAG_WIDTH-1:0] tag;
        mac_op_t                   op;
        logic [`MAC_WIDTH-1:0]     a;
        logic [`MAC_WIDTH-1:0]     b;
        logic [`MAC_WIDTH-1:0]     acc;
    } mac_cmd_t;

    // Flags are {negative, zero}.
    typedef struct packed
    {
        logic [`MAC_TAG_WIDTH-1:0] tag;
        logic [`MAC_WIDTH-1:0]     product;
        logic [1:0]                flags;
    } mac_res_t;

endpackage

`default_nettype wire

//--- mac_defines.svh
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// Operand and result width of the multiply-accumulate path.
`define MAC_WIDTH 32

// Request tags wrap modulo 2**MAC_TAG_WIDTH.
`define MAC_TAG_WIDTH 4

`define MAC_CMD_DEPTH 4
`define MAC_RES_DEPTH 4

`endif
